/* tb.f */
+incdir+verification
source/fifo_pkg.sv
source/memory_mlab.sv
source/fifo_control.sv
source/fifo_output_stage.sv
source/mlab_fifo.sv
verification/mlab_fifo_tb.sv

/* Bender.yml */
package:
  name: mlab_fifo

sources:
  # Package first, then the RTL from leaves to top
  - files:
      - source/fifo_pkg.sv
      - source/memory_mlab.sv
      - source/fifo_control.sv
      - source/fifo_output_stage.sv
      - source/mlab_fifo.sv

  # Testbench with its included stimulus table
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/mlab_fifo_tb.sv

__________________________________________________
META
Run: cff77d61cf7fc6458896f25c3ff35d4097c9f1e5
Model: claude-opus-4-7
Started: 2026-05-21T18:26:50Z

/* verification/fifo_test_table.svh */
`ifndef FIFO_TEST_TABLE_SVH
`define FIFO_TEST_TABLE_SVH

// Rows give name, cycles, push and pop chance in percent, random data flag, and the
// fill level and full flag expected after the row's last edge where -1 skips the check

localparam int NUM_ROWS = 19;

typedef struct {
    string name;
    int    cycles;
    int    push_pct;
    int    pop_pct;
    bit    random_data;
    int    end_level;
    int    end_full;
} test_row_t;

test_row_t test_table [NUM_ROWS] = '{
    // Reset state and pops into an empty FIFO
    '{"idle_after_reset",    8,   0,   0, 1'b0,  0,  0},
    '{"pop_when_empty",      4,   0, 100, 1'b0,  0,  0},
    // One word through the 3-edge latency
    '{"single_push",         1, 100,   0, 1'b0,  1,  0},
    '{"single_latency",      3,   0,   0, 1'b0,  1,  0},
    '{"single_pop",          1,   0, 100, 1'b0,  0,  0},
    '{"settle",              4,   0,   0, 1'b0,  0,  0},
    // Ordering under random pop patterns
    '{"burst_random_pop",   60, 100,  50, 1'b1, -1, -1},
    '{"burst_drain",        50,   0, 100, 1'b0,  0,  0},
    '{"random_mix",        200,  60,  60, 1'b1, -1, -1},
    '{"random_drain",       50,   0, 100, 1'b0,  0,  0},
    // Full flag and dropped pushes
    '{"fill_to_full",       40, 100,   0, 1'b0, 34,  1},
    '{"push_while_full",     5, 100,   0, 1'b0, 34,  1},
    '{"pop_first_words",     4,   0, 100, 1'b0, 30,  0},
    // One word per cycle at a steady level
    '{"steady_high",        40, 100, 100, 1'b0, 30,  0},
    '{"full_drain",         45,   0, 100, 1'b0,  0,  0},
    '{"prime_low",           5, 100,   0, 1'b0,  5,  0},
    '{"prime_wait",          4,   0,   0, 1'b0,  5,  0},
    '{"steady_low",         30, 100, 100, 1'b1,  5,  0},
    '{"final_drain",        20,   0, 100, 1'b0,  0,  0}
};

`endif

/* verification/mlab_fifo_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mlab_fifo_tb
    import fifo_pkg::*;
();

    localparam int HALF_PERIOD     = 10;
    localparam int CLK_PERIOD      = 2 * HALF_PERIOD;
    localparam int RESET_CYCLES    = 10;
    localparam int LATENCY         = 3;
    localparam int WATCHDOG_MARGIN = 100;

    `include "fifo_test_table.svh"

    logic                   clk = 1'b0;
    logic                   rstReadAddr;
    logic                   push;
    logic [DATA_WIDTH-1:0]  push_data;
    logic                   full;
    logic                   pop;
    logic [DATA_WIDTH-1:0]  pop_data;
    logic                   pop_valid;
    logic [LEVEL_WIDTH-1:0] fill_level;

    // Reference queue and the edge each word was accepted on
    logic [DATA_WIDTH-1:0]  model_data [$];
    int                     model_time [$];

    int                     edge_count      = 0;
    int                     pending_end_row = -1;
    int                     check_count     = 0;
    int                     error_count     = 0;
    logic [DATA_WIDTH-1:0]  next_word       = 1;

    always #(HALF_PERIOD) clk = ~clk;

    mlab_fifo DUT (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .push        (push),
        .push_data   (push_data),
        .full        (full),
        .pop         (pop),
        .pop_data    (pop_data),
        .pop_valid   (pop_valid),
        .fill_level  (fill_level)
    );

    task automatic check_value(input string test_name, input string signal_name,
                               input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     test_name, signal_name, expected, actual);
        end
    endtask

    // Head word is visible once it is LATENCY edges old
    function automatic logic model_valid();
        if (model_data.size() == 0) begin
            return 1'b0;
        end
        return (edge_count - model_time[0]) >= LATENCY;
    endfunction

    task automatic check_outputs(input string test_name);
        logic exp_valid;

        exp_valid = model_valid();
        check_value(test_name, "fill_level", model_data.size(), fill_level);
        check_value(test_name, "full", model_data.size() == FIFO_CAPACITY, full);
        check_value(test_name, "pop_valid", exp_valid, pop_valid);
        if (exp_valid) begin
            check_value(test_name, "pop_data", model_data[0], pop_data);
        end
    endtask

    task automatic check_row_end(input int row);
        string end_name;

        end_name = {test_table[row].name, "_end"};
        if (test_table[row].end_level >= 0) begin
            check_value(end_name, "fill_level", test_table[row].end_level, fill_level);
        end
        if (test_table[row].end_full >= 0) begin
            check_value(end_name, "full", test_table[row].end_full, full);
        end
    endtask

    // Runs from just after one rising edge to just after the next
    task automatic run_cycle(input int row);
        logic                  do_push;
        logic                  do_pop;
        logic [DATA_WIDTH-1:0] word;
        logic                  push_ok;
        logic                  pop_ok;

        do_push = ($urandom_range(99) < test_table[row].push_pct);
        do_pop  = ($urandom_range(99) < test_table[row].pop_pct);
        if (test_table[row].random_data) begin
            word = DATA_WIDTH'($urandom);
        end else begin
            word = next_word;
            if (do_push) begin
                next_word = next_word + 1'b1;
            end
        end

        push      <= do_push;
        pop       <= do_pop;
        push_data <= word;

        @(negedge clk);
        // Previous row has just seen its last edge
        if (pending_end_row >= 0) begin
            check_row_end(pending_end_row);
            pending_end_row = -1;
        end
        check_outputs(test_table[row].name);
        push_ok = do_push && (model_data.size() < FIFO_CAPACITY);
        pop_ok  = do_pop && model_valid();

        @(posedge clk);
        edge_count++;
        if (pop_ok) begin
            void'(model_data.pop_front());
            void'(model_time.pop_front());
        end
        if (push_ok) begin
            model_data.push_back(word);
            model_time.push_back(edge_count);
        end
    endtask

    initial begin
        int row;
        int cycle;

        void'($urandom(27));
        rstReadAddr = 1'b1;
        push        = 1'b0;
        pop         = 1'b0;
        push_data   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstReadAddr <= 1'b0;

        for (row = 0; row < NUM_ROWS; row++) begin
            for (cycle = 0; cycle < test_table[row].cycles; cycle++) begin
                run_cycle(row);
            end
            pending_end_row = row;
        end

        push <= 1'b0;
        pop  <= 1'b0;
        @(negedge clk);
        check_row_end(pending_end_row);
        check_outputs("final");

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Limit derived from the table length
    initial begin
        int total_cycles;
        int i;

        total_cycles = RESET_CYCLES + WATCHDOG_MARGIN;
        for (i = 0; i < NUM_ROWS; i++) begin
            total_cycles += test_table[i].cycles;
        end
        #(total_cycles * CLK_PERIOD);
        $display("Watchdog timeout: the run did not end within %0d cycles", total_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* source/mlab_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module mlab_fifo
    import fifo_pkg::*;
(
    input  wire logic                   clk,
    input  wire logic                   rstReadAddr,

    input  wire logic                   push,
    input  wire logic [DATA_WIDTH-1:0]  push_data,
    output logic                        full,

    input  wire logic                   pop,
    output logic      [DATA_WIDTH-1:0]  pop_data,
    output logic                        pop_valid,

    output logic      [LEVEL_WIDTH-1:0] fill_level
);

    logic                       mem_write_enable;
    logic [MEM_DEPTH_LOG2-1:0]  mem_write_addr;
    logic [MEM_DEPTH_LOG2-1:0]  mem_read_addr;
    logic                       mem_read_stall;
    logic [DATA_WIDTH-1:0]      mem_data_out;
    logic                       stage_load;
    logic [OUT_COUNT_WIDTH-1:0] stage_count;

    fifo_control u_control (
        .clk                (clk),
        .rstReadAddr        (rstReadAddr),
        .push               (push),
        .pop                (pop),
        .pop_valid          (pop_valid),
        .out_count          (stage_count),
        .full               (full),
        .fill_level         (fill_level),
        .write_enable       (mem_write_enable),
        .write_addr         (mem_write_addr),
        .read_addr          (mem_read_addr),
        .read_address_stall (mem_read_stall),
        .load               (stage_load)
    );

    memory_mlab #(
        .WIDTH      (DATA_WIDTH),
        .DEPTH_LOG2 (MEM_DEPTH_LOG2)
    ) u_memory (
        .clk                (clk),
        .rstReadAddr        (rstReadAddr),
        .write_enable       (mem_write_enable),
        .write_addr         (mem_write_addr),
        .data_in            (push_data),
        .read_address_stall (mem_read_stall),
        .read_addr          (mem_read_addr),
        .data_out           (mem_data_out)
    );

    fifo_output_stage u_output_stage (
        .clk         (clk),
        .rstReadAddr (rstReadAddr),
        .load        (stage_load),
        .data_in     (mem_data_out),
        .pop         (pop),
        .pop_data    (pop_data),
        .pop_valid   (pop_valid),
        .out_count   (stage_count)
    );

endmodule

`default_nettype wire

/* source/fifo_output_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_output_stage
    import fifo_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rstReadAddr,

    input  wire logic                       load,
    input  wire logic [DATA_WIDTH-1:0]      data_in,
    input  wire logic                       pop,

    output logic      [DATA_WIDTH-1:0]      pop_data,
    output logic                            pop_valid,
    output logic      [OUT_COUNT_WIDTH-1:0] out_count
);

    // Entry 0 is the head
    logic [DATA_WIDTH-1:0] entry_0;
    logic [DATA_WIDTH-1:0] entry_1;
    logic                  pop_accept;

    assign pop_accept = pop && pop_valid;
    assign pop_valid  = (out_count != '0);
    assign pop_data   = entry_0;

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            out_count <= '0;
        end else if (load && !pop_accept) begin
            out_count <= out_count + 1'b1;
        end else if (pop_accept && !load) begin
            out_count <= out_count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case ({load, pop_accept})
            2'b10: begin
                if (out_count == '0) begin
                    entry_0 <= data_in;
                end else begin
                    entry_1 <= data_in;
                end
            end
            2'b01: begin
                entry_0 <= entry_1;
            end
            2'b11: begin
                // Head leaves while the new word joins behind the survivor
                if (out_count == OUT_COUNT_WIDTH'(1)) begin
                    entry_0 <= data_in;
                end else begin
                    entry_0 <= entry_1;
                    entry_1 <= data_in;
                end
            end
            default: begin
            end
        endcase
    end

    // Control must never prefetch into a full stage
    a_no_overflow: assert property (
        @(posedge clk) disable iff (rstReadAddr)
        !(load && (out_count == OUT_COUNT_WIDTH'(OUT_STAGE_DEPTH)) && !pop_accept)
    ) else $error("fifo_output_stage: load into full stage without pop");

endmodule

`default_nettype wire

/* source/fifo_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fifo_control
    import fifo_pkg::*;
(
    input  wire logic                       clk,
    input  wire logic                       rstReadAddr,

    input  wire logic                       push,
    input  wire logic                       pop,
    input  wire logic                       pop_valid,
    input  wire logic [OUT_COUNT_WIDTH-1:0] out_count,

    output logic                            full,
    output logic      [LEVEL_WIDTH-1:0]     fill_level,

    // Memory write port
    output logic                            write_enable,
    output logic      [MEM_DEPTH_LOG2-1:0]  write_addr,

    // Memory read port
    output logic      [MEM_DEPTH_LOG2-1:0]  read_addr,
    output logic                            read_address_stall,

    // Output stage capture strobe
    output logic                            load
);

    // One extra bit to tell full from empty
    logic [MEM_DEPTH_LOG2:0]  wr_ptr;
    logic [MEM_DEPTH_LOG2:0]  rd_ptr;
    logic [MEM_DEPTH_LOG2:0]  commit_ptr;

    // Stage 0 matches the memory write register, stage 1 the array write
    logic [1:0]               commit_shift;

    logic                     push_accept;
    logic                     pop_accept;
    logic                     fetch;
    logic [MEM_DEPTH_LOG2:0]  committed_words;
    logic [OUT_COUNT_WIDTH:0] stage_demand;

    assign push_accept = push && !full;
    assign pop_accept  = pop && pop_valid;

    assign full = (fill_level == LEVEL_WIDTH'(FIFO_CAPACITY));

    // Words already in the array and not yet fetched
    assign committed_words = commit_ptr - rd_ptr
                           + (MEM_DEPTH_LOG2 + 1)'(commit_shift[1]);

    // Entries the output stage will hold once the pending load lands
    assign stage_demand = (OUT_COUNT_WIDTH + 1)'(out_count)
                        + (OUT_COUNT_WIDTH + 1)'(load)
                        - (OUT_COUNT_WIDTH + 1)'(pop_accept);

    assign fetch = (committed_words != '0)
                && (stage_demand < (OUT_COUNT_WIDTH + 1)'(OUT_STAGE_DEPTH));

    assign write_enable       = push_accept;
    assign write_addr         = wr_ptr[MEM_DEPTH_LOG2-1:0];
    assign read_addr          = rd_ptr[MEM_DEPTH_LOG2-1:0];
    assign read_address_stall = !fetch;

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            commit_ptr   <= '0;
            commit_shift <= '0;
            load         <= 1'b0;
        end else begin
            if (push_accept) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fetch) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (commit_shift[1]) begin
                commit_ptr <= commit_ptr + 1'b1;
            end
            commit_shift <= {commit_shift[0], push_accept};
            // Fetched word shows on data_out in the next cycle
            load <= fetch;
        end
    end

    // Level moves only on an unbalanced push or pop
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            fill_level <= '0;
        end else if (push_accept && !pop_accept) begin
            fill_level <= fill_level + 1'b1;
        end else if (pop_accept && !push_accept) begin
            fill_level <= fill_level - 1'b1;
        end
    end

    a_ptr_distance: assert property (
        @(posedge clk) disable iff (rstReadAddr)
        (wr_ptr - rd_ptr) <= (MEM_DEPTH_LOG2 + 1)'(MEM_DEPTH)
    ) else $error("fifo_control: pointer distance %0d beyond memory depth",
                  wr_ptr - rd_ptr);

    // Every accepted word is in memory, in flight to the output stage or held there
    a_level_bound: assert property (
        @(posedge clk) disable iff (rstReadAddr)
        (fill_level <= LEVEL_WIDTH'(FIFO_CAPACITY))
            && (fill_level == LEVEL_WIDTH'(wr_ptr - rd_ptr)
                              + LEVEL_WIDTH'(load) + LEVEL_WIDTH'(out_count))
    ) else $error("fifo_control: fill level %0d beyond capacity or off the word count",
                  fill_level);

endmodule

`default_nettype wire

/* source/memory_mlab.sv */
`timescale 1ns/1ps
`default_nettype none

module memory_mlab
    import fifo_pkg::*;
#(
    parameter int WIDTH = DATA_WIDTH,
    parameter int DEPTH_LOG2 = MEM_DEPTH_LOG2
) (
    input  wire logic                  clk,
    input  wire logic                  rstReadAddr,

    // Write side
    input  wire logic                  write_enable,
    input  wire logic [DEPTH_LOG2-1:0] write_addr,
    input  wire logic [WIDTH-1:0]      data_in,

    // Read side
    input  wire logic                  read_address_stall,
    input  wire logic [DEPTH_LOG2-1:0] read_addr,
    output logic      [WIDTH-1:0]      data_out
);

    logic [WIDTH-1:0] mem_array [0:(1 << DEPTH_LOG2) - 1];

    logic                  write_enable_reg;
    logic [DEPTH_LOG2-1:0] write_addr_reg;
    logic [WIDTH-1:0]      write_data_reg;

    logic [DEPTH_LOG2-1:0] read_addr_reg;
    logic                  read_active_reg;

    // Array written one edge after the write port registers
    always_ff @(posedge clk) begin
        if (write_enable_reg) begin
            mem_array[write_addr_reg] <= write_data_reg;
        end
        write_enable_reg <= write_enable;
        write_addr_reg   <= write_addr;
        write_data_reg   <= data_in;
    end

    // Read address register clears like the MLAB address aclr
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            read_addr_reg   <= '0;
            read_active_reg <= 1'b0;
        end else begin
            if (!read_address_stall) begin
                read_addr_reg <= read_addr;
            end
            read_active_reg <= !read_address_stall;
        end
    end

    // Unregistered output
    assign data_out = mem_array[read_addr_reg];

    // Mixed-port collision would return undefined data on the real block
    a_no_read_during_write: assert property (
        @(posedge clk) disable iff (rstReadAddr)
        !(write_enable_reg && read_active_reg && (write_addr_reg == read_addr_reg))
    ) else $error("memory_mlab: read and write of address %0d in one cycle", read_addr_reg);

endmodule

`default_nettype wire

/* source/fifo_pkg.sv */
`default_nettype none

package fifo_pkg;

    // FIFO word
    localparam int DATA_WIDTH = 20;

    // Distributed memory geometry
    localparam int MEM_DEPTH_LOG2 = 5;
    localparam int MEM_DEPTH = 1 << MEM_DEPTH_LOG2;

    // Show-ahead stage after the memory
    localparam int OUT_STAGE_DEPTH = 2;

    // Words held in memory plus output stage
    localparam int FIFO_CAPACITY = MEM_DEPTH + OUT_STAGE_DEPTH;

    // Counter widths
    localparam int LEVEL_WIDTH = $clog2(FIFO_CAPACITY + 1);
    localparam int OUT_COUNT_WIDTH = $clog2(OUT_STAGE_DEPTH + 1);

endpackage

`default_nettype wire
